/* common/lsu_settings.svh */
// lsu settings: datapath width, address width, memory size and slave read latency
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// ====================
// datapath
// ====================
// register and bus data width
`define LSU_XLEN 64
// byte address width
`define LSU_AW 64

// ====================
// memory slave
// ====================
// doublewords in the slave array, power of two
`define LSU_MEM_WORDS 256
// cycles from read address accept to read valid, at least 1
`define LSU_RD_LAT 2

`endif

/* common/lsu_pkg.sv */
// lsu types: width opcodes, channel states, request and writeback words
`include "lsu_settings.svh"

package lsu_pkg;

  // ====================
  // opcodes
  // ====================
  // load width, signed forms first
  typedef enum logic [2:0] {
    LD_B  = 3'd0,
    LD_H  = 3'd1,
    LD_W  = 3'd2,
    LD_D  = 3'd3,
    LD_BU = 3'd4,
    LD_HU = 3'd5,
    LD_WU = 3'd6
  } ld_width_e;

  // store width
  typedef enum logic [1:0] {
    ST_B = 2'd0,
    ST_H = 2'd1,
    ST_W = 2'd2,
    ST_D = 2'd3
  } st_width_e;

  // ====================
  // channel states
  // ====================
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_DATA = 2'd1,
    WR_RESP = 2'd2
  } wr_state_e;

  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_WAIT = 1'b1
  } rd_state_e;

  // okay response code on b and r
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // one load or store request from the pipeline
  typedef struct packed {
    logic [`LSU_AW-1:0]   addr;
    logic [`LSU_XLEN-1:0] wdata;
    ld_width_e            ld_width;
    st_width_e            st_width;
    logic [4:0]           rd;
  } lsu_req_t;

  // register file writeback
  typedef struct packed {
    logic                 wen;
    logic [4:0]           rd;
    logic [`LSU_XLEN-1:0] data;
  } lsu_wb_t;

endpackage

/* lsu/lsu_store_align.sv */
// store alignment: places store data on its byte lanes and builds the byte strobe
`include "lsu_settings.svh"

module lsu_store_align (
  input  lsu_pkg::st_width_e    st_width_i,
  input  logic [2:0]            addr_lo_i,
  input  logic [`LSU_XLEN-1:0]  wdata_i,
  output logic [`LSU_XLEN-1:0]  data_o,
  output logic [`LSU_XLEN/8-1:0] strb_o
);
  import lsu_pkg::*;

  localparam int SB = `LSU_XLEN / 8;

  logic [SB-1:0] base_strb;
  logic          aligned;

  // low bytes move up to the addressed lane
  assign data_o = wdata_i << {addr_lo_i, 3'b000};

  always_comb begin
    case (st_width_i)
      ST_B: begin
        base_strb = SB'(8'h01);
        aligned   = 1'b1;
      end
      ST_H: begin
        base_strb = SB'(8'h03);
        aligned   = (addr_lo_i[0] == 1'b0);
      end
      ST_W: begin
        base_strb = SB'(8'h0f);
        aligned   = (addr_lo_i[1:0] == 2'b00);
      end
      default: begin
        base_strb = '1;
        aligned   = (addr_lo_i == 3'b000);
      end
    endcase
  end

  assign strb_o = base_strb << addr_lo_i;

  // natural alignment only, no lane wrap
  always_comb begin
    assert final (aligned)
      else $error("store offset %0d not aligned to width %s", addr_lo_i, st_width_i.name());
  end

endmodule

/* lsu/lsu_load_align.sv */
// load alignment: extracts the addressed field of a doubleword and extends it
`include "lsu_settings.svh"

module lsu_load_align (
  input  lsu_pkg::ld_width_e   ld_width_i,
  input  logic [2:0]           addr_lo_i,
  input  logic [`LSU_XLEN-1:0] rdata_i,
  output logic [`LSU_XLEN-1:0] data_o
);
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] shifted;

  // addressed byte down to lane 0
  assign shifted = rdata_i >> {addr_lo_i, 3'b000};

  always_comb begin
    case (ld_width_i)
      // signed forms copy the field's top bit
      LD_B: begin
        data_o = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      LD_H: begin
        data_o = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      LD_W: begin
        data_o = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
      end
      // unsigned forms
      LD_BU: begin
        data_o = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
      end
      LD_HU: begin
        data_o = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
      end
      LD_WU: begin
        data_o = {{(`LSU_XLEN-32){1'b0}}, shifted[31:0]};
      end
      // full doubleword
      default: begin
        data_o = shifted;
      end
    endcase
  end

endmodule

/* lsu/lsu_core.sv */
// load/store unit with write and read channel FSMs, request capture and writeback
`include "lsu_settings.svh"

module lsu_core (
  input  logic                    clk,
  input  logic                    rst,
  input  lsu_pkg::lsu_req_t       req_i,
  input  logic                    ld_i,
  input  logic                    st_i,
  output lsu_pkg::lsu_wb_t        wb_o,
  output logic                    st_done_o,
  output logic [1:0]              st_resp_o,
  output logic                    aw_valid_o,
  output logic [`LSU_AW-1:0]      aw_addr_o,
  input  logic                    aw_ready_i,
  output logic                    w_valid_o,
  output logic [`LSU_XLEN-1:0]    w_data_o,
  output logic [`LSU_XLEN/8-1:0]  w_strb_o,
  input  logic                    w_ready_i,
  input  logic                    b_valid_i,
  input  logic [1:0]              b_resp_i,
  output logic                    b_ready_o,
  output logic                    ar_valid_o,
  output logic [`LSU_AW-1:0]      ar_addr_o,
  input  logic                    ar_ready_i,
  input  logic                    r_valid_i,
  input  logic [`LSU_XLEN-1:0]    r_data_i,
  input  logic [1:0]              r_resp_i,
  output logic                    r_ready_o
);
  import lsu_pkg::*;

  wr_state_e                wr_state_q, wr_state_d;
  logic                     aw_hold_q;
  logic [`LSU_AW-1:0]       aw_addr_q;
  logic [`LSU_XLEN-1:0]     w_data_q, st_data;
  logic [`LSU_XLEN/8-1:0]   w_strb_q, st_strb;
  logic [2:0]               st_lo;
  logic [1:0]               st_resp_q;
  rd_state_e                rd_state_q, rd_state_d;
  logic                     ar_hold_q;
  logic [`LSU_AW-1:0]       ar_addr_q;
  ld_width_e                ld_width_q;
  logic [4:0]               rd_q;
  logic [`LSU_XLEN-1:0]     ld_data;
  logic                     aw_hs, w_hs, b_hs, ar_hs, r_hs;

  assign aw_hs = aw_valid_o & aw_ready_i;
  assign w_hs  = w_valid_o & w_ready_i;
  assign b_hs  = b_valid_i & b_ready_o;
  assign ar_hs = ar_valid_o & ar_ready_i;
  assign r_hs  = r_valid_i & r_ready_o;

  // ====================
  // write channel
  // ====================
  // offset only matters in the strobe cycle
  assign st_lo = st_i ? req_i.addr[2:0] : 3'b000;

  lsu_store_align u_store_align (
    .st_width_i (req_i.st_width),
    .addr_lo_i  (st_lo),
    .wdata_i    (req_i.wdata),
    .data_o     (st_data),
    .strb_o     (st_strb)
  );

  // valid straight from the strobe and held until accepted
  assign aw_valid_o = st_i | aw_hold_q;
  assign aw_addr_o  = st_i ? req_i.addr : aw_addr_q;
  assign w_valid_o  = (wr_state_q == WR_DATA);
  assign w_data_o   = w_data_q;
  assign w_strb_o   = w_strb_q;
  assign b_ready_o  = (wr_state_q == WR_RESP);
  assign st_done_o  = b_hs;
  assign st_resp_o  = b_hs ? b_resp_i : st_resp_q;

  always_comb begin
    wr_state_d = wr_state_q;
    case (wr_state_q)
      WR_IDLE: if (aw_hs) wr_state_d = WR_DATA;
      WR_DATA: if (w_hs) wr_state_d = WR_RESP;
      WR_RESP: if (b_valid_i) wr_state_d = WR_IDLE;
      default: wr_state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state_q <= WR_IDLE;
      aw_hold_q  <= 1'b0;
      st_resp_q  <= AXI_RESP_OKAY;
    end else begin
      wr_state_q <= wr_state_d;
      if (aw_hs) begin
        aw_hold_q <= 1'b0;
      end else if (st_i) begin
        aw_hold_q <= 1'b1;
      end
      if (b_hs) begin
        st_resp_q <= b_resp_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (st_i) begin
      aw_addr_q <= req_i.addr;
      w_data_q  <= st_data;
      w_strb_q  <= st_strb;
    end
  end

  // ====================
  // read channel
  // ====================
  assign ar_valid_o = ld_i | ar_hold_q;
  assign ar_addr_o  = ld_i ? req_i.addr : ar_addr_q;
  assign r_ready_o  = (rd_state_q == RD_WAIT);

  always_comb begin
    rd_state_d = rd_state_q;
    case (rd_state_q)
      RD_IDLE: if (ar_hs) rd_state_d = RD_WAIT;
      RD_WAIT: if (r_valid_i) rd_state_d = RD_IDLE;
      default: rd_state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state_q <= RD_IDLE;
      ar_hold_q  <= 1'b0;
    end else begin
      rd_state_q <= rd_state_d;
      if (ar_hs) begin
        ar_hold_q <= 1'b0;
      end else if (ld_i) begin
        ar_hold_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ld_i) begin
      ar_addr_q  <= req_i.addr;
      ld_width_q <= req_i.ld_width;
      rd_q       <= req_i.rd;
    end
  end

  lsu_load_align u_load_align (
    .ld_width_i (ld_width_q),
    .addr_lo_i  (ar_addr_q[2:0]),
    .rdata_i    (r_data_i),
    .data_o     (ld_data)
  );

  // writeback in the R handshake cycle
  assign wb_o = '{wen: r_hs, rd: rd_q, data: ld_data};

  // ====================
  // protocol checks
  // ====================
  a_st_idle: assert property (@(posedge clk) disable iff (rst)
    st_i |-> (wr_state_q == WR_IDLE) && !aw_hold_q);
  a_ld_idle: assert property (@(posedge clk) disable iff (rst)
    ld_i |-> (rd_state_q == RD_IDLE) && !ar_hold_q);
  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o));
  // no error handling on the load path
  a_r_okay: assert property (@(posedge clk) disable iff (rst)
    r_hs |-> r_resp_i == AXI_RESP_OKAY);

endmodule

/* logic/axi_ram_slave.sv */
// memory slave: doubleword RAM behind AXI-style write, response and read channels
`include "lsu_settings.svh"

module axi_ram_slave (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    aw_valid_i,
  input  logic [`LSU_AW-1:0]      aw_addr_i,
  output logic                    aw_ready_o,
  input  logic                    w_valid_i,
  input  logic [`LSU_XLEN-1:0]    w_data_i,
  input  logic [`LSU_XLEN/8-1:0]  w_strb_i,
  output logic                    w_ready_o,
  output logic                    b_valid_o,
  output logic [1:0]              b_resp_o,
  input  logic                    b_ready_i,
  input  logic                    ar_valid_i,
  input  logic [`LSU_AW-1:0]      ar_addr_i,
  output logic                    ar_ready_o,
  output logic                    r_valid_o,
  output logic [`LSU_XLEN-1:0]    r_data_o,
  output logic [1:0]              r_resp_o,
  input  logic                    r_ready_i
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
  localparam int CNT_W = $clog2(`LSU_RD_LAT + 1);

  logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];
  wr_state_e            wr_state_q;
  rd_state_e            rd_state_q;
  logic [IDX_W-1:0]     aw_idx_q;
  logic [CNT_W-1:0]     lat_cnt_q;
  logic [`LSU_XLEN-1:0] r_data_q;
  logic                 aw_hs, w_hs, ar_hs;

  assign aw_hs = aw_valid_i & aw_ready_o;
  assign w_hs  = w_valid_i & w_ready_o;
  assign ar_hs = ar_valid_i & ar_ready_o;

  // ====================
  // write side
  // ====================
  // address first, then data, then response
  assign aw_ready_o = (wr_state_q == WR_IDLE);
  assign w_ready_o  = (wr_state_q == WR_DATA);
  assign b_valid_o  = (wr_state_q == WR_RESP);
  assign b_resp_o   = AXI_RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state_q <= WR_IDLE;
    end else begin
      case (wr_state_q)
        WR_IDLE: if (aw_hs) wr_state_q <= WR_DATA;
        WR_DATA: if (w_hs) wr_state_q <= WR_RESP;
        WR_RESP: if (b_ready_i) wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  // byte merge under strobe, read snapshot at address accept
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_idx_q <= aw_addr_i[IDX_W+2:3];
    end
    if (w_hs) begin
      for (int b = 0; b < `LSU_XLEN / 8; b++) begin
        if (w_strb_i[b]) begin
          mem[aw_idx_q][8*b +: 8] <= w_data_i[8*b +: 8];
        end
      end
    end
    if (ar_hs) begin
      r_data_q <= mem[ar_addr_i[IDX_W+2:3]];
    end
  end

  // ====================
  // read side
  // ====================
  assign ar_ready_o = (rd_state_q == RD_IDLE);
  assign r_valid_o  = (rd_state_q == RD_WAIT) && (lat_cnt_q == '0);
  assign r_data_o   = r_data_q;
  assign r_resp_o   = AXI_RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state_q <= RD_IDLE;
      lat_cnt_q  <= '0;
    end else begin
      case (rd_state_q)
        RD_IDLE: begin
          if (ar_hs) begin
            rd_state_q <= RD_WAIT;
            lat_cnt_q  <= CNT_W'(`LSU_RD_LAT - 1);
          end
        end
        default: begin
          // count down, then hold r_valid until taken
          if (lat_cnt_q != '0) begin
            lat_cnt_q <= lat_cnt_q - 1'b1;
          end else if (r_ready_i) begin
            rd_state_q <= RD_IDLE;
          end
        end
      endcase
    end
  end

  a_w_after_aw: assert property (@(posedge clk) disable iff (rst)
    w_valid_i |-> wr_state_q == WR_DATA);

endmodule

/* logic/mem_subsys_top.sv */
// memory subsystem top: load/store unit joined to the RAM slave
`include "lsu_settings.svh"

module mem_subsys_top (
  input  logic              clk,
  input  logic              rst,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              ld_i,
  input  logic              st_i,
  output lsu_pkg::lsu_wb_t  wb_o,
  output logic              st_done_o,
  output logic [1:0]        st_resp_o
);

  // write address, data and response
  logic                   aw_valid, aw_ready;
  logic [`LSU_AW-1:0]     aw_addr;
  logic                   w_valid, w_ready;
  logic [`LSU_XLEN-1:0]   w_data;
  logic [`LSU_XLEN/8-1:0] w_strb;
  logic                   b_valid, b_ready;
  logic [1:0]             b_resp;
  // read address and data
  logic                   ar_valid, ar_ready;
  logic [`LSU_AW-1:0]     ar_addr;
  logic                   r_valid, r_ready;
  logic [`LSU_XLEN-1:0]   r_data;
  logic [1:0]             r_resp;

  lsu_core u_lsu (
    .clk (clk), .rst (rst),
    .req_i (req_i), .ld_i (ld_i), .st_i (st_i),
    .wb_o (wb_o), .st_done_o (st_done_o), .st_resp_o (st_resp_o),
    .aw_valid_o (aw_valid), .aw_addr_o (aw_addr), .aw_ready_i (aw_ready),
    .w_valid_o (w_valid), .w_data_o (w_data), .w_strb_o (w_strb), .w_ready_i (w_ready),
    .b_valid_i (b_valid), .b_resp_i (b_resp), .b_ready_o (b_ready),
    .ar_valid_o (ar_valid), .ar_addr_o (ar_addr), .ar_ready_i (ar_ready),
    .r_valid_i (r_valid), .r_data_i (r_data), .r_resp_i (r_resp), .r_ready_o (r_ready)
  );

  axi_ram_slave u_ram (
    .clk (clk), .rst (rst),
    .aw_valid_i (aw_valid), .aw_addr_i (aw_addr), .aw_ready_o (aw_ready),
    .w_valid_i (w_valid), .w_data_i (w_data), .w_strb_i (w_strb), .w_ready_o (w_ready),
    .b_valid_o (b_valid), .b_resp_o (b_resp), .b_ready_i (b_ready),
    .ar_valid_i (ar_valid), .ar_addr_i (ar_addr), .ar_ready_o (ar_ready),
    .r_valid_o (r_valid), .r_data_o (r_data), .r_resp_o (r_resp), .r_ready_i (r_ready)
  );

endmodule

/* dv/mem_subsys_tb.sv */
// memory subsystem testbench driving directed and random loads and stores against a shadow memory
`include "lsu_settings.svh"

module mem_subsys_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import lsu_pkg::*;

  localparam logic [63:0] BASE = 64'h0000_0000_8000_0000;
  localparam int WIN_WORDS = 32;
  localparam int N_RAND = 300;
  // fill, test 1, test 2, test 3, random ops with up to two requests each
  localparam int N_OPS = WIN_WORDS + 8 + 28 + 58 + 2 * N_RAND;
  localparam int TIMEOUT_CYCLES = N_OPS * (`LSU_RD_LAT + 10) + 16;
  localparam int WAIT_LIMIT = `LSU_RD_LAT + 20;

  logic     clk;
  logic     rst;
  lsu_req_t req_i;
  logic     ld_i;
  logic     st_i;
  lsu_wb_t  wb_o;
  logic     st_done_o;
  logic [1:0] st_resp_o;

  logic [`LSU_XLEN-1:0] shadow [`LSU_MEM_WORDS];
  lsu_wb_t exp_q [$];
  int errors = 0;
  int loads_issued = 0;
  int loads_done = 0;
  int stores_issued = 0;
  int stores_done = 0;
  int cycle_cnt = 0;

  mem_subsys_top u_mem_subsys_top (
    .clk (clk), .rst (rst), .req_i (req_i), .ld_i (ld_i), .st_i (st_i),
    .wb_o (wb_o), .st_done_o (st_done_o), .st_resp_o (st_resp_o)
  );

  always #10 clk = ~clk;

  // ====================
  // reference model
  // ====================
  function automatic int st_bytes(st_width_e w);
    case (w)
      ST_B: return 1;
      ST_H: return 2;
      ST_W: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic int ld_bytes(ld_width_e w);
    case (w)
      LD_B, LD_BU: return 1;
      LD_H, LD_HU: return 2;
      LD_W, LD_WU: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic int word_index(logic [63:0] addr);
    return int'((addr >> 3) % `LSU_MEM_WORDS);
  endfunction

  // only the addressed bytes take the new data
  function automatic logic [63:0] merge_store(logic [63:0] old, st_width_e w,
                                              logic [2:0] off, logic [63:0] data);
    logic [63:0] res;
    res = old;
    for (int b = 0; b < st_bytes(w); b++) begin
      res[8*(off+b) +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [63:0] load_value(logic [63:0] dw, ld_width_e w, logic [2:0] off);
    logic [63:0] val;
    int n;
    logic sgn;
    n = ld_bytes(w);
    sgn = (w == LD_B) || (w == LD_H) || (w == LD_W);
    val = '0;
    for (int b = 0; b < n; b++) begin
      val[8*b +: 8] = dw[8*(off+b) +: 8];
    end
    if (sgn && val[8*n-1]) begin
      for (int i = 8 * n; i < 64; i++) begin
        val[i] = 1'b1;
      end
    end
    return val;
  endfunction

  // ====================
  // driver tasks
  // ====================
  task automatic wait_stores();
    int waited;
    waited = 0;
    while (stores_done != stores_issued && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (stores_done != stores_issued) begin
      errors++;
      $display("store did not complete at %0t, no st_done_o pulse seen", $time);
      stores_issued = stores_done;
    end
    @(negedge clk);
  endtask

  task automatic wait_loads();
    int waited;
    waited = 0;
    while (loads_done != loads_issued && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (loads_done != loads_issued) begin
      errors++;
      $display("load did not complete at %0t, no writeback seen", $time);
      loads_issued = loads_done;
      exp_q.delete();
    end
    @(negedge clk);
  endtask

  task automatic issue_store(logic [63:0] addr, st_width_e w, logic [63:0] data);
    int idx;
    wait_stores();
    idx = word_index(addr);
    shadow[idx] = merge_store(shadow[idx], w, addr[2:0], data);
    stores_issued++;
    req_i = '{addr: addr, wdata: data, ld_width: LD_D, st_width: w, rd: 5'd0};
    st_i = 1'b1;
    @(negedge clk);
    st_i = 1'b0;
  endtask

  // expected value fixed at issue ahead of any later store
  task automatic issue_load(logic [63:0] addr, ld_width_e w, logic [4:0] rd);
    lsu_wb_t exp;
    wait_stores();
    wait_loads();
    exp.wen = 1'b1;
    exp.rd = rd;
    exp.data = load_value(shadow[word_index(addr)], w, addr[2:0]);
    exp_q.push_back(exp);
    loads_issued++;
    req_i = '{addr: addr, wdata: '0, ld_width: w, st_width: ST_D, rd: rd};
    ld_i = 1'b1;
    @(negedge clk);
    ld_i = 1'b0;
  endtask

  // ====================
  // checker and timeout
  // ====================
  always @(negedge clk) begin
    lsu_wb_t exp;
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, operations did not finish", cycle_cnt);
      $display("errors: %0d, loads: %0d, stores: %0d", errors + 1, loads_done, stores_done);
      $display("Simulation finished: FAIL");
      $finish;
    end
    if (rst) begin
      if (wb_o.wen !== 1'b0 || st_done_o !== 1'b0) begin
        errors++;
        $display("writeback or store done seen during reset at %0t", $time);
      end
    end else begin
      if (wb_o.wen === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("writeback at %0t with no load outstanding", $time);
        end else begin
          exp = exp_q.pop_front();
          loads_done++;
          if (wb_o.data !== exp.data) begin
            errors++;
            $display("Error at %0t: wb_o.data = %h, expected %h", $time, wb_o.data, exp.data);
          end
          if (wb_o.rd !== exp.rd) begin
            errors++;
            $display("Error at %0t: wb_o.rd = %0d, expected %0d", $time, wb_o.rd, exp.rd);
          end
        end
      end else if (wb_o.wen !== 1'b0) begin
        errors++;
        $display("writeback enable unknown at %0t", $time);
      end
      if (st_done_o === 1'b1) begin
        if (stores_done == stores_issued) begin
          errors++;
          $display("store done at %0t with no store outstanding", $time);
        end else begin
          stores_done++;
        end
        if (st_resp_o !== 2'b00) begin
          errors++;
          $display("Error at %0t: st_resp_o = %b, expected %b", $time, st_resp_o, 2'b00);
        end
      end
    end
  end

  // ====================
  // stimulus
  // ====================
  initial begin
    ld_width_e lw_list [6];
    logic [63:0] addr;
    logic [63:0] pat;
    int n;
    int kind;
    ld_width_e lw;
    st_width_e sw;
    lw_list = '{LD_B, LD_BU, LD_H, LD_HU, LD_W, LD_WU};
    clk = 1'b0;
    rst = 1'b1;
    ld_i = 1'b0;
    st_i = 1'b0;
    req_i = '0;
    void'($urandom(58));
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // fill the test window with a pattern from the whole address
    for (int i = 0; i < WIN_WORDS; i++) begin
      addr = BASE + 64'(i * 8);
      issue_store(addr, ST_D,
                  {addr[63:32] ^ addr[31:0] ^ 32'ha5c3_0f96, ~addr[31:0]});
    end
    // full doubleword round trip
    for (int i = 0; i < 4; i++) begin
      addr = BASE + 64'(i * 24);
      issue_store(addr, ST_D, {$urandom, $urandom});
      issue_load(addr, LD_D, 5'(i + 1));
    end
    // partial stores at every aligned offset
    for (int w = 0; w < 3; w++) begin
      sw = st_width_e'(w);
      for (int off = 0; off < 8; off += st_bytes(sw)) begin
        addr = BASE + 64'(8 * (w + 4));
        issue_store(addr + 64'(off), sw, {$urandom, $urandom});
        issue_load(addr, LD_D, 5'(off + 8));
      end
    end
    // sign and zero extension with field tops set then clear
    for (int p = 0; p < 2; p++) begin
      pat = (p == 0) ? 64'hf1e2_d3c4_b5a6_9788 : 64'h7162_5344_3526_1708;
      addr = BASE + 64'h40;
      issue_store(addr, ST_D, pat);
      for (int i = 0; i < 6; i++) begin
        for (int off = 0; off < 8; off += ld_bytes(lw_list[i])) begin
          issue_load(addr + 64'(off), lw_list[i], 5'(i + 16));
        end
      end
    end
    // random mix where kind 3 issues a store behind an outstanding load
    for (int k = 0; k < N_RAND; k++) begin
      kind = $urandom % 4;
      addr = BASE + 64'(8 * ($urandom % WIN_WORDS));
      if (kind < 2) begin
        sw = st_width_e'($urandom % 4);
        n = st_bytes(sw);
        issue_store(addr + 64'(($urandom % 8) & ~(n - 1)), sw, {$urandom, $urandom});
      end else begin
        lw = ld_width_e'($urandom % 7);
        n = ld_bytes(lw);
        issue_load(addr + 64'(($urandom % 8) & ~(n - 1)), lw, 5'($urandom % 32));
        if (kind == 3) begin
          issue_store(BASE + 64'(8 * ($urandom % WIN_WORDS)), ST_D, {$urandom, $urandom});
        end
      end
    end

    wait_loads();
    wait_stores();
    repeat (4) @(negedge clk);
    if (loads_done != loads_issued || stores_done != stores_issued || exp_q.size() != 0) begin
      errors++;
      $display("completion counts do not match the requests issued");
    end
    $display("errors: %0d, loads: %0d, stores: %0d", errors, loads_done, stores_done);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+common
common/lsu_pkg.sv
lsu/lsu_store_align.sv
lsu/lsu_load_align.sv
lsu/lsu_core.sv
logic/axi_ram_slave.sv
logic/mem_subsys_top.sv
dv/mem_subsys_tb.sv
